// File: tb_input_flits.txt
// columns: channel index, flit value (hex)
// the first six channel 0 entries are sent while its NoC output is blocked
0 a5a50001
1 3c3c1001
0 5a5a0002
2 0f0f2001
0 deadbeef
0 12345678
1 c3c31002
0 fedcba98
2 f0f02002
0 00000000
1 ffffffff
0 80000001
2 7ffffffe
0 aaaa5555
1 5555aaaa
0 0badcafe
2 13579bdf
0 2468ace0

// File: list.f
+incdir+.
vc_bridge_pkg.sv
link_rx_unpack.sv
vc_lane.sv
link_tx_arbiter.sv
vc_bridge_top.sv
tb_vc_bridge.sv

// File: Makefile
# Verilator simulation of the VC bridge testbench

VERILATOR ?= verilator
TOP       ?= tb_vc_bridge
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= TESTS PASSED

.PHONY: sim clean

# build, run and search the output for the pass message
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: tb_vc_bridge.sv
/*
 * VC bridge testbench
 * Loops the link back onto itself through a random stall stage, injects
 * flits from a data file and checks delivery, credit flow and fairness
 */

`include "vc_bridge_cfg.svh"

module tb_vc_bridge import vc_bridge_pkg::*; ();

  localparam int NumCh     = `VC_NUM_CHANNELS;
  localparam int Depth     = `VC_QUEUE_DEPTH;
  localparam int ClkPeriod = 20;
  localparam int MaxLines  = 64;
  // channel 0 flits sent while its NoC output is blocked
  localparam int BlockLen  = Depth + 2;

  logic                 clk_i;
  logic                 rst_i;
  vc_flit_t [NumCh-1:0] noc_in_i;
  logic [NumCh-1:0]     noc_in_ready_o;
  vc_flit_t [NumCh-1:0] noc_out_o;
  logic [NumCh-1:0]     noc_out_ready_i;
  link_beat_t           link_out_o;
  logic                 link_out_ready_i;
  link_beat_t           link_in_i;
  logic                 link_in_ready_o;

  logic [31:0] stim_mem [2*MaxLines];
  flit_data_t  chan_flits [NumCh][MaxLines];
  int          chan_cnt [NumCh];
  int          num_lines;
  logic        stim_loaded;

  int          sent_idx [NumCh];
  int          recv_idx [NumCh];
  int          inject_limit [NumCh];
  int          link_data_cnt [NumCh];
  int          cred_ret [NumCh];
  int          since_last [NumCh];
  logic        block_ch0;
  logic        fair_on;

  logic [15:0] lfsr_q;
  logic        link_stall;
  link_beat_t  prev_beat;
  logic        prev_held;

  vc_bridge_top dut (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .noc_in_i         (noc_in_i),
    .noc_in_ready_o   (noc_in_ready_o),
    .noc_out_o        (noc_out_o),
    .noc_out_ready_i  (noc_out_ready_i),
    .link_out_o       (link_out_o),
    .link_out_ready_i (link_out_ready_i),
    .link_in_i        (link_in_i),
    .link_in_ready_o  (link_in_ready_o)
  );

  // the stall stage blocks both directions of the loopback together
  assign link_out_ready_i = ~link_stall & link_in_ready_o;

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////////////////////
  // helpers and compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  task automatic check_flit(input flit_data_t got, input flit_data_t exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("error at %0t: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_credit(input credit_t got, input credit_t exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("error at %0t: %s is %0d, expected %0d", $time, what, got, exp));
    end
  endtask

  task automatic check_beat_field(input vc_id_t got, input vc_id_t exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("error at %0t: %s is %0d, expected %0d", $time, what, got, exp));
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("error at %0t: %s is %b, expected %b", $time, what, got, exp));
    end
  endtask

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    logic fb;
    fb = state[15] ^ state[13] ^ state[12] ^ state[10];
    return {state[14:0], fb};
  endfunction

  function automatic logic all_waiting();
    logic busy;
    busy = 1'b1;
    for (int c = 0; c < NumCh; c++) begin
      if (link_data_cnt[c] >= chan_cnt[c]) begin
        busy = 1'b0;
      end
    end
    return busy;
  endfunction

  function automatic logic delivery_done();
    logic done;
    done = 1'b1;
    for (int c = 0; c < NumCh; c++) begin
      if (recv_idx[c] != chan_cnt[c] || link_data_cnt[c] != chan_cnt[c]) begin
        done = 1'b0;
      end
    end
    return done;
  endfunction

  task automatic load_stimulus();
    int ch;
    // end marker in the channel column that differs per address
    for (int i = 0; i < 2 * MaxLines; i++) begin
      stim_mem[i] = 32'hff00_0000 | 32'(i);
    end
    $readmemh("tb_input_flits.txt", stim_mem);
    num_lines = 0;
    while (num_lines < MaxLines && stim_mem[2*num_lines] < 32'(NumCh)) begin
      ch = int'(stim_mem[2*num_lines]);
      chan_flits[ch][chan_cnt[ch]] = stim_mem[2*num_lines+1];
      chan_cnt[ch]++;
      num_lines++;
    end
    if (num_lines == 0) begin
      abort_run("the data file tb_input_flits.txt holds no stimulus");
    end
    stim_loaded = 1'b1;
  endtask

  // link_in stalls only for data toward a full receive queue
  task automatic check_link_ready();
    int   vc;
    int   fill;
    logic exp_ready;
    exp_ready = 1'b1;
    if (link_in_i.data_valid) begin
      vc        = int'(link_in_i.data_vc);
      fill      = link_data_cnt[vc] - recv_idx[vc];
      exp_ready = (fill < Depth);
    end
    check_flag(link_in_ready_o, exp_ready, "link_in ready");
  endtask

  // no channel may wait more than one round of the others
  task automatic track_fairness(input int vc);
    if (fair_on && all_waiting()) begin
      for (int c = 0; c < NumCh; c++) begin
        if (c != vc) begin
          since_last[c]++;
          if (since_last[c] > NumCh - 1) begin
            abort_run($sformatf("error at %0t: channel %0d skipped a full round", $time, c));
          end
        end
      end
      since_last[vc] = 0;
    end else begin
      for (int c = 0; c < NumCh; c++) begin
        since_last[c] = 0;
      end
    end
  endtask

  task automatic track_link();
    int v;
    if (prev_held) begin
      check_flag(link_out_o.valid, prev_beat.valid, "held beat valid");
      check_flag(link_out_o.data_valid, prev_beat.data_valid, "held beat data_valid");
      check_beat_field(link_out_o.data_vc, prev_beat.data_vc, "held beat data_vc");
      check_flit(link_out_o.data, prev_beat.data, "held beat data");
      check_beat_field(link_out_o.cred_vc, prev_beat.cred_vc, "held beat cred_vc");
      check_credit(link_out_o.credits, prev_beat.credits, "held beat credits");
    end
    prev_beat = link_out_o;
    prev_held = link_out_o.valid & ~link_out_ready_i;
    if (link_out_o.valid && !link_out_o.data_valid && link_out_o.credits == '0) begin
      abort_run($sformatf("error at %0t: beat carries neither data nor credits", $time));
    end
    if (link_out_o.valid && link_out_ready_i) begin
      if (link_out_o.data_valid) begin
        v = int'(link_out_o.data_vc);
        track_fairness(v);
        link_data_cnt[v]++;
        // the beat's own credits count only toward later beats
        if (link_data_cnt[v] > Depth + cred_ret[v]) begin
          abort_run($sformatf("error at %0t: channel %0d sent %0d beats on %0d credits",
                              $time, v, link_data_cnt[v], Depth + cred_ret[v]));
        end
      end
      cred_ret[int'(link_out_o.cred_vc)] += int'(link_out_o.credits);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus and monitors
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin : drive_inputs
    logic [15:0] s1;
    logic [15:0] s2;
    s1 = lfsr_next(lfsr_q);
    s2 = lfsr_next(s1);
    lfsr_q = s2;
    link_stall = s1[0] & s2[0];
    link_in_i = link_out_o;
    link_in_i.valid = link_out_o.valid & ~link_stall;
    for (int c = 0; c < NumCh; c++) begin
      noc_in_i[c].valid = (sent_idx[c] < inject_limit[c]);
      noc_in_i[c].data  = noc_in_i[c].valid ? chan_flits[c][sent_idx[c]] : '0;
    end
    noc_out_ready_i = {{(NumCh-1){1'b1}}, ~block_ch0};
  end

  always @(posedge clk_i) begin : monitor
    if (!rst_i) begin
      if (link_in_i.valid) begin
        check_link_ready();
      end
      for (int c = 0; c < NumCh; c++) begin
        if (noc_in_i[c].valid && noc_in_ready_o[c]) begin
          sent_idx[c]++;
        end
        if (noc_out_o[c].valid && noc_out_ready_i[c]) begin
          if (recv_idx[c] >= chan_cnt[c]) begin
            abort_run($sformatf("channel %0d delivered more flits than were injected", c));
          end
          check_flit(noc_out_o[c].data, chan_flits[c][recv_idx[c]],
                     $sformatf("channel %0d flit %0d", c, recv_idx[c]));
          recv_idx[c]++;
        end
      end
      track_link();
    end
  end

  initial begin : watchdog
    wait (stim_loaded);
    #(200 * num_lines * ClkPeriod);
    $display("timeout: the run did not finish within %0d cycles", 200 * num_lines);
    $display("TESTS FAILED");
    $fatal(1);
  end

  initial begin : main
    clk_i = 1'b0;
    rst_i = 1'b1;
    noc_in_i = '0;
    noc_out_ready_i = '1;
    link_in_i = '0;
    link_stall = 1'b0;
    lfsr_q = 16'd10733;
    block_ch0 = 1'b0;
    fair_on = 1'b0;
    prev_beat = '0;
    prev_held = 1'b0;
    stim_loaded = 1'b0;
    for (int c = 0; c < NumCh; c++) begin
      chan_cnt[c] = 0;
      sent_idx[c] = 0;
      recv_idx[c] = 0;
      inject_limit[c] = 0;
      link_data_cnt[c] = 0;
      cred_ret[c] = 0;
      since_last[c] = 0;
    end
    load_stimulus();

    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    for (int c = 0; c < NumCh; c++) begin
      check_flag(noc_in_ready_o[c], 1'b0, $sformatf("noc_in_ready %0d in reset", c));
    end
    rst_i = 1'b0;
    @(negedge clk_i);
    check_flag(link_out_o.valid, 1'b0, "link_out valid after reset");
    for (int c = 0; c < NumCh; c++) begin
      check_flag(noc_out_o[c].valid, 1'b0, $sformatf("noc_out valid %0d after reset", c));
      check_flag(noc_in_ready_o[c], 1'b1, $sformatf("noc_in_ready %0d after reset", c));
    end

    // channel 0 alone with its NoC output blocked
    if (chan_cnt[0] < BlockLen) begin
      abort_run("the data file holds too few flits for channel 0");
    end
    block_ch0 <= 1'b1;
    inject_limit[0] <= BlockLen;
    while (link_data_cnt[0] < Depth) @(negedge clk_i);
    repeat (20) @(negedge clk_i);
    check_credit(credit_t'(link_data_cnt[0]), credit_t'(Depth), "channel 0 beats while blocked");
    block_ch0 <= 1'b0;
    while (recv_idx[0] < BlockLen) @(negedge clk_i);

    // every channel loaded at once
    fair_on <= 1'b1;
    for (int c = 0; c < NumCh; c++) begin
      inject_limit[c] <= chan_cnt[c];
    end
    while (!delivery_done()) @(negedge clk_i);
    fair_on <= 1'b0;
    repeat (20) @(negedge clk_i);

    if (delivery_done()) begin
      $display("TESTS PASSED");
      $finish;
    end else begin
      $display("flits were lost or sent twice after the traffic had drained");
      $display("TESTS FAILED");
      $fatal(1);
    end
  end

endmodule

// File: vc_bridge_top.sv
/*
 * VC bridge top
 * Carries several NoC channels over one credit-controlled stream link
 */

`include "vc_bridge_cfg.svh"

module vc_bridge_top import vc_bridge_pkg::*; (
  input  logic                              clk_i,
  input  logic                              rst_i,
  // NoC channels
  input  vc_flit_t [`VC_NUM_CHANNELS-1:0]   noc_in_i,
  output logic [`VC_NUM_CHANNELS-1:0]       noc_in_ready_o,
  output vc_flit_t [`VC_NUM_CHANNELS-1:0]   noc_out_o,
  input  logic [`VC_NUM_CHANNELS-1:0]       noc_out_ready_i,
  // stream link
  output link_beat_t                        link_out_o,
  input  logic                              link_out_ready_i,
  input  link_beat_t                        link_in_i,
  output logic                              link_in_ready_o
);

  localparam int NumCh = `VC_NUM_CHANNELS;

  logic [NumCh-1:0]       lane_ready;
  logic [NumCh-1:0]       rx_data_valid;
  logic [NumCh-1:0]       rx_cred_valid;
  flit_data_t             rx_data;
  credit_t                rx_cred;
  logic [NumCh-1:0]       tx_valid;
  flit_data_t [NumCh-1:0] tx_data;
  credit_t [NumCh-1:0]    pending;
  logic [NumCh-1:0]       tx_grant;
  logic [NumCh-1:0]       cred_taken;

  // link in, split toward the lanes
  link_rx_unpack u_rx_unpack (
    .link_in_i       (link_in_i),
    .link_in_ready_o (link_in_ready_o),
    .lane_ready_i    (lane_ready),
    .rx_data_valid_o (rx_data_valid),
    .rx_cred_valid_o (rx_cred_valid),
    .rx_data_o       (rx_data),
    .rx_cred_o       (rx_cred)
  );

  for (genvar g = 0; g < NumCh; g++) begin : g_lane
    vc_lane u_lane (
      .clk_i           (clk_i),
      .rst_i           (rst_i),
      .lane_id_i       (vc_id_t'(g)),
      .noc_in_i        (noc_in_i[g]),
      .noc_in_ready_o  (noc_in_ready_o[g]),
      .noc_out_o       (noc_out_o[g]),
      .noc_out_ready_i (noc_out_ready_i[g]),
      .rx_data_valid_i (rx_data_valid[g]),
      .rx_data_i       (rx_data),
      .rx_data_ready_o (lane_ready[g]),
      .rx_cred_valid_i (rx_cred_valid[g]),
      .rx_cred_i       (rx_cred),
      .tx_valid_o      (tx_valid[g]),
      .tx_data_o       (tx_data[g]),
      .pending_o       (pending[g]),
      .tx_grant_i      (tx_grant[g]),
      .cred_taken_i    (cred_taken[g])
    );
  end

  // lanes drained onto link out
  link_tx_arbiter u_tx_arbiter (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .tx_valid_i       (tx_valid),
    .tx_data_i        (tx_data),
    .pending_i        (pending),
    .tx_grant_o       (tx_grant),
    .cred_taken_o     (cred_taken),
    .link_out_o       (link_out_o),
    .link_out_ready_i (link_out_ready_i)
  );

endmodule

// File: link_tx_arbiter.sv
/*
 * Link transmit arbiter
 * Round-robin lane selection, credit attachment, credit-only beats and
 * the registered link output stage
 */

`include "vc_bridge_cfg.svh"

module link_tx_arbiter import vc_bridge_pkg::*; (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic [`VC_NUM_CHANNELS-1:0] tx_valid_i,
  input  flit_data_t [`VC_NUM_CHANNELS-1:0] tx_data_i,
  input  credit_t [`VC_NUM_CHANNELS-1:0]    pending_i,
  output logic [`VC_NUM_CHANNELS-1:0] tx_grant_o,
  output logic [`VC_NUM_CHANNELS-1:0] cred_taken_o,
  output link_beat_t                  link_out_o,
  input  logic                        link_out_ready_i
);

  localparam int NumCh = `VC_NUM_CHANNELS;

  vc_id_t       last_q;
  logic         data_found;
  vc_id_t       data_idx;
  cred_return_t best_cred;
  logic         force_cred;
  link_beat_t   beat_d;
  link_beat_t   beat_q;
  logic         load_en;
  logic         load;

  ////////////////////////////////////////////////////////////////////////////
  // lane selection
  ////////////////////////////////////////////////////////////////////////////

  // first valid lane after the last one granted
  always_comb begin : rr_pick
    int cand;
    data_found = 1'b0;
    data_idx   = '0;
    for (int k = 1; k <= NumCh; k++) begin
      cand = (int'(last_q) + k) % NumCh;
      if (!data_found && tx_valid_i[cand]) begin
        data_found = 1'b1;
        data_idx   = vc_id_t'(cand);
      end
    end
  end

  // largest pending count wins, strict compare keeps the lowest index on a tie
  always_comb begin : cred_pick
    best_cred = '0;
    for (int i = 0; i < NumCh; i++) begin
      if (pending_i[i] > best_cred.credits) begin
        best_cred.vc      = vc_id_t'(i);
        best_cred.credits = pending_i[i];
      end
    end
  end

  assign force_cred = (best_cred.credits != '0) &&
                      (best_cred.credits >= credit_t'(`VC_FORCE_THRESH));

  always_comb begin : beat_build
    beat_d.valid      = data_found | force_cred;
    beat_d.data_valid = data_found;
    beat_d.data_vc    = data_idx;
    beat_d.data       = tx_data_i[data_idx];
    beat_d.cred_vc    = best_cred.vc;
    beat_d.credits    = best_cred.credits;
  end

  ////////////////////////////////////////////////////////////////////////////
  // output register
  ////////////////////////////////////////////////////////////////////////////

  // load only into an empty or draining register
  assign load_en = ~beat_q.valid | link_out_ready_i;
  assign load    = load_en & beat_d.valid;

  always_comb begin : handshake_back
    tx_grant_o   = '0;
    cred_taken_o = '0;
    if (load && data_found) begin
      tx_grant_o[data_idx] = 1'b1;
    end
    if (load && (best_cred.credits != '0)) begin
      cred_taken_o[best_cred.vc] = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      beat_q.valid <= 1'b0;
      last_q       <= vc_id_t'(NumCh - 1);
    end else begin
      if (load_en) begin
        beat_q <= beat_d;
      end
      if (load && data_found) begin
        last_q <= data_idx;
      end
    end
  end

  assign link_out_o = beat_q;

  a_link_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    link_out_o.valid && !link_out_ready_i |=> $stable(link_out_o))
    else $error("link beat changed under back-pressure");

endmodule

// File: vc_lane.sv
/*
 * Virtual-channel lane
 * Receive queue toward the NoC, transmit holding register, credit counter
 * and the count of credits owed back to the far end
 */

`include "vc_bridge_cfg.svh"

module vc_lane import vc_bridge_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_i,
  input  vc_id_t     lane_id_i,
  // NoC side
  input  vc_flit_t   noc_in_i,
  output logic       noc_in_ready_o,
  output vc_flit_t   noc_out_o,
  input  logic       noc_out_ready_i,
  // from the link unpacker
  input  logic       rx_data_valid_i,
  input  flit_data_t rx_data_i,
  output logic       rx_data_ready_o,
  input  logic       rx_cred_valid_i,
  input  credit_t    rx_cred_i,
  // toward the link arbiter
  output logic       tx_valid_o,
  output flit_data_t tx_data_o,
  output credit_t    pending_o,
  input  logic       tx_grant_i,
  input  logic       cred_taken_i
);

  localparam int      PtrW  = $clog2(`VC_QUEUE_DEPTH);
  localparam credit_t Depth = credit_t'(`VC_QUEUE_DEPTH);

  flit_data_t      queue_mem [`VC_QUEUE_DEPTH];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  credit_t         fill_q;
  logic            push;
  logic            pop;

  credit_t         pending_q;

  logic            hold_valid_q;
  logic            hold_valid_d;
  logic            in_ready_q;
  logic            take_in;
  flit_data_t      hold_data_q;

  credit_t         credit_q;
  credit_t         cred_add;

  function automatic logic [PtrW-1:0] next_ptr(input logic [PtrW-1:0] ptr);
    if (ptr == PtrW'(`VC_QUEUE_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // receive queue, link to NoC
  ////////////////////////////////////////////////////////////////////////////

  assign rx_data_ready_o = (fill_q != Depth);
  assign push            = rx_data_valid_i & rx_data_ready_o;
  assign noc_out_o.valid = (fill_q != '0);
  assign noc_out_o.data  = queue_mem[rd_ptr_q];
  assign pop             = noc_out_o.valid & noc_out_ready_i;

  always_ff @(posedge clk_i) begin
    if (push) begin
      queue_mem[wr_ptr_q] <= rx_data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      fill_q   <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      fill_q <= fill_q + credit_t'(push) - credit_t'(pop);
    end
  end

  // every pop frees one slot the far end may reuse
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pending_q <= '0;
    end else if (cred_taken_i) begin
      pending_q <= credit_t'(pop);
    end else if (pop) begin
      pending_q <= pending_q + 1'b1;
    end
  end

  assign pending_o = pending_q;

  ////////////////////////////////////////////////////////////////////////////
  // transmit side, NoC to link
  ////////////////////////////////////////////////////////////////////////////

  assign take_in      = noc_in_i.valid & in_ready_q;
  assign hold_valid_d = take_in | (hold_valid_q & ~tx_grant_i);

  // registered ready, low through reset
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      hold_valid_q <= 1'b0;
      in_ready_q   <= 1'b0;
    end else begin
      hold_valid_q <= hold_valid_d;
      in_ready_q   <= ~hold_valid_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (take_in) begin
      hold_data_q <= noc_in_i.data;
    end
  end

  assign noc_in_ready_o = in_ready_q;

  // credits mirror the free slots of the far-end queue
  assign cred_add = rx_cred_valid_i ? rx_cred_i : '0;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      credit_q <= Depth;
    end else begin
      credit_q <= credit_q + cred_add - credit_t'(tx_grant_i);
    end
  end

  assign tx_valid_o = hold_valid_q & (credit_q != '0);
  assign tx_data_o  = hold_data_q;

  // far end sends only against credit, so data never meets a full queue
  a_no_write_full: assert property (@(posedge clk_i) disable iff (rst_i)
    rx_data_valid_i |-> rx_data_ready_o)
    else $error("lane %0d: data delivered to a full receive queue", lane_id_i);

  a_credit_bound: assert property (@(posedge clk_i) disable iff (rst_i)
    credit_q <= Depth)
    else $error("lane %0d: credit count above queue depth", lane_id_i);

endmodule

// File: link_rx_unpack.sv
/*
 * Link receive unpacker
 * Splits each incoming beat into a data delivery and a credit delivery
 */

`include "vc_bridge_cfg.svh"

module link_rx_unpack import vc_bridge_pkg::*; (
  input  link_beat_t                  link_in_i,
  output logic                        link_in_ready_o,
  input  logic [`VC_NUM_CHANNELS-1:0] lane_ready_i,
  output logic [`VC_NUM_CHANNELS-1:0] rx_data_valid_o,
  output logic [`VC_NUM_CHANNELS-1:0] rx_cred_valid_o,
  output flit_data_t                  rx_data_o,
  output credit_t                     rx_cred_o
);

  localparam int NumCh = `VC_NUM_CHANNELS;

  logic [NumCh-1:0] data_sel;
  logic [NumCh-1:0] cred_sel;
  logic             target_ready;

  // one-hot channel decode for both halves of the beat
  always_comb begin : vc_decode
    for (int i = 0; i < NumCh; i++) begin
      data_sel[i] = (link_in_i.data_vc == vc_id_t'(i));
      cred_sel[i] = (link_in_i.cred_vc == vc_id_t'(i));
    end
  end

  assign target_ready = |(data_sel & lane_ready_i);

  // only a data beat toward a full queue stalls, credits always sink
  assign link_in_ready_o = ~link_in_i.data_valid | target_ready;

  assign rx_data_valid_o = {NumCh{link_in_i.valid & link_in_i.data_valid}} & data_sel;
  assign rx_cred_valid_o = {NumCh{link_in_i.valid & link_in_ready_o}} & cred_sel;

  assign rx_data_o = link_in_i.data;
  assign rx_cred_o = link_in_i.credits;

  // far-end arbiter only ever names lanes that exist
  always_comb begin : vc_range_check
    if (link_in_i.valid) begin
      assert ((int'(link_in_i.data_vc) < NumCh) && (int'(link_in_i.cred_vc) < NumCh))
        else $error("link beat names a channel beyond %0d", NumCh - 1);
    end
  end

endmodule

// File: vc_bridge_pkg.sv
/*
 * VC bridge types
 * Flit, link beat and credit types shared by every bridge block
 */

`include "vc_bridge_cfg.svh"

package vc_bridge_pkg;

  // flit payload
  typedef logic [`VC_FLIT_W-1:0] flit_data_t;

  // channel index, up to four channels
  typedef logic [1:0] vc_id_t;

  // credit count, also used for queue fill levels
  typedef logic [`VC_CRED_W-1:0] credit_t;

  // one flit toward or from the NoC
  typedef struct packed {
    logic       valid;
    flit_data_t data;
  } vc_flit_t;

  ////////////////////////////////////////////////////////////////////////////
  // link beat, a data part and a credit part for possibly different channels
  ////////////////////////////////////////////////////////////////////////////
  typedef struct packed {
    logic       valid;
    logic       data_valid;
    vc_id_t     data_vc;
    flit_data_t data;
    vc_id_t     cred_vc;
    credit_t    credits;
  } link_beat_t;

  // credits owed to one channel
  typedef struct packed {
    vc_id_t  vc;
    credit_t credits;
  } cred_return_t;

endpackage

// File: vc_bridge_cfg.svh
/*
 * VC bridge configuration
 * Sizing of the credit-based virtual-channel link bridge
 */

`ifndef VC_BRIDGE_CFG_SVH
`define VC_BRIDGE_CFG_SVH

////////////////////////////////////////////////////////////////////////////
// channel and payload sizing
////////////////////////////////////////////////////////////////////////////

// independent NoC channels sharing the link
`define VC_NUM_CHANNELS 3

// flit payload bits, same for every channel
`define VC_FLIT_W 32

////////////////////////////////////////////////////////////////////////////
// credit flow control
////////////////////////////////////////////////////////////////////////////

// receive queue entries per channel, also the credits held after reset
`define VC_QUEUE_DEPTH 4

// credit field, must hold the full queue depth
`define VC_CRED_W 3

// pending returns that force a credit-only beat on an idle link
`define VC_FORCE_THRESH (`VC_QUEUE_DEPTH - 1)

`endif
